// ==== data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
  input  logic              clk_5M,
  input  soc_pkg::ram_req_t ram_req,
  output logic [31:0]       rdata
);

  // one word per entry, four independent byte lanes
  logic [31:0] mem [soc_pkg::RAM_WORDS];
  logic [31:0] rdata_q;

  // byte lane writes
  always_ff @(posedge clk_5M) begin
    for (int i = 0; i < 4; i++) begin
      if (ram_req.we[i]) begin
        mem[ram_req.word][i*8 +: 8] <= ram_req.wdata[i*8 +: 8];
      end
    end
  end

  // read register only moves on a read strobe
  always_ff @(posedge clk_5M) begin
    if (ram_req.rd) begin
      rdata_q <= mem[ram_req.word];
    end
  end

  assign rdata = rdata_q;

endmodule

// ==== display_select.sv ====
`timescale 1ns/1ps

module display_select (
  input  logic        clk_5M,
  input  logic        rst,
  input  logic        debug,
  input  logic [31:0] debug_word,
  input  logic [31:0] disp_value,
  output logic [31:0] show_value
);

  logic [31:0] show_q;

  // one register stage so the scanner never sees a half update
  always_ff @(posedge clk_5M) begin
    if (rst) begin
      show_q <= 32'h0;
    end else if (debug) begin
      // core debug word wins while debug is held
      show_q <= debug_word;
    end else begin
      show_q <= disp_value;
    end
  end

  assign show_value = show_q;

endmodule

// ==== mem_controller.sv ====
`timescale 1ns/1ps

module mem_controller (
  input  logic              clk_5M,
  input  logic              rst,
  input  soc_pkg::bus_req_t bus_req,
  output logic [31:0]       bus_rdata,
  output soc_pkg::ram_req_t ram_req,
  input  logic [31:0]       ram_rdata,
  output logic [31:0]       disp_value,
  output logic [15:0]       led,
  output logic              tx_start,
  output logic [7:0]        tx_byte,
  input  logic              tx_busy,
  output logic              rx_pop,
  input  logic [7:0]        rx_byte,
  input  logic              rx_present
);

  logic               is_ram;
  logic               is_io;
  logic               io_wr;
  logic               io_rd;
  logic [2:0]         reg_idx;
  logic [31:0]        disp_q;
  logic [15:0]        led_q;
  logic [31:0]        disp_next;
  logic [31:0]        led_next;
  logic [31:0]        io_rdata;
  soc_pkg::uart_stat_t stat;
  // read target of the previous cycle
  logic               rd_ram_q;
  logic [31:0]        io_rdata_q;

  // replace only the enabled byte lanes
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // region decode on the top nibble
  assign is_ram  = (bus_req.addr.ram.region == soc_pkg::REGION_RAM);
  assign is_io   = (bus_req.addr.io.region == soc_pkg::REGION_IO);
  assign io_wr   = bus_req.wr && is_io;
  assign io_rd   = bus_req.rd && is_io;
  assign reg_idx = bus_req.addr.io.reg_idx;

  // ram gets strobes only for its own region
  assign ram_req.we    = (bus_req.wr && is_ram) ? bus_req.be : 4'b0000;
  assign ram_req.rd    = bus_req.rd && is_ram;
  assign ram_req.word  = bus_req.addr.ram.word;
  assign ram_req.wdata = bus_req.wdata;

  // tx write dropped while a frame is on the line
  assign tx_start = io_wr && (reg_idx == soc_pkg::IO_UART_TX) && !tx_busy;
  assign tx_byte  = bus_req.wdata[7:0];
  // pop happens in the strobe cycle, byte is captured below
  assign rx_pop   = io_rd && (reg_idx == soc_pkg::IO_UART_RX);

  assign disp_next = merge_lanes(disp_q, bus_req.wdata, bus_req.be);
  // led only has the two low lanes
  assign led_next  = merge_lanes({16'h0000, led_q}, bus_req.wdata, bus_req.be);

  always_comb begin
    stat            = '0;
    stat.rx_present = rx_present;
    stat.tx_busy    = tx_busy;
  end

  // register file read mux
  always_comb begin
    case (reg_idx)
      soc_pkg::IO_DISP:      io_rdata = disp_q;
      soc_pkg::IO_LED:       io_rdata = {16'h0000, led_q};
      soc_pkg::IO_UART_RX:   io_rdata = {24'h000000, rx_byte};
      soc_pkg::IO_UART_STAT: io_rdata = stat;
      // tx register is write only
      default:               io_rdata = 32'h0;
    endcase
  end

  always_ff @(posedge clk_5M) begin
    if (rst) begin
      disp_q <= 32'h0;
      led_q  <= 16'h0000;
    end else if (io_wr) begin
      if (reg_idx == soc_pkg::IO_DISP) begin
        disp_q <= disp_next;
      end
      if (reg_idx == soc_pkg::IO_LED) begin
        led_q <= led_next[15:0];
      end
    end
  end

  // remember where the read went, hold it until the next read
  always_ff @(posedge clk_5M) begin
    if (rst) begin
      rd_ram_q   <= 1'b0;
      io_rdata_q <= 32'h0;
    end else if (bus_req.rd) begin
      rd_ram_q   <= is_ram;
      // unmapped regions read zero
      io_rdata_q <= is_io ? io_rdata : 32'h0;
    end
  end

  // ram holds its own read register between reads
  assign bus_rdata  = rd_ram_q ? ram_rdata : io_rdata_q;
  assign disp_value = disp_q;
  assign led        = led_q;

endmodule

// ==== mmio_sva.sv ====
`timescale 1ns/1ps

module mmio_sva (
  input logic              clk_5M,
  input logic              rst,
  input soc_pkg::bus_req_t bus_req,
  input logic              tx_start,
  input logic              tx_busy,
  input logic              rx_pop,
  input logic              rx_present
);

  // one strobe at a time on the bus
  assert property (@(posedge clk_5M) disable iff (rst)
    !(bus_req.wr && bus_req.rd))
    else $error("write and read strobe high in the same cycle");

  // an accepted start puts the transmitter in busy
  assert property (@(posedge clk_5M) disable iff (rst)
    tx_start |=> tx_busy)
    else $error("tx_busy not high after tx_start");

  // popped byte clears the present flag
  assert property (@(posedge clk_5M) disable iff (rst)
    rx_pop |=> !rx_present)
    else $error("rx_present still high after rx_pop");

endmodule

bind mem_controller mmio_sva mmio_sva_i (
  .clk_5M     (clk_5M),
  .rst        (rst),
  .bus_req    (bus_req),
  .tx_start   (tx_start),
  .tx_busy    (tx_busy),
  .rx_pop     (rx_pop),
  .rx_present (rx_present)
);

// ==== mmio_top.sv ====
`timescale 1ns/1ps

module mmio_top (
  input  logic              clk_5M,
  input  logic              rst,
  input  soc_pkg::bus_req_t bus_req,
  output logic [31:0]       bus_rdata,
  input  logic              debug,
  input  logic [31:0]       debug_word,
  input  logic              rx,
  output logic              tx,
  output logic [15:0]       led,
  output logic [7:0]        an,
  output logic [6:0]        sev_out
);

  // controller to ram
  soc_pkg::ram_req_t ram_req;
  logic [31:0]       ram_rdata;
  // display path
  logic [31:0]       disp_value;
  logic [31:0]       show_value;
  // uart strobes and status
  logic              tx_start;
  logic [7:0]        tx_byte;
  logic              tx_busy;
  logic              rx_pop;
  logic [7:0]        rx_byte;
  logic              rx_present;

  mem_controller mem_controller_i (
    .clk_5M     (clk_5M),
    .rst        (rst),
    .bus_req    (bus_req),
    .bus_rdata  (bus_rdata),
    .ram_req    (ram_req),
    .ram_rdata  (ram_rdata),
    .disp_value (disp_value),
    .led        (led),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy),
    .rx_pop     (rx_pop),
    .rx_byte    (rx_byte),
    .rx_present (rx_present)
  );

  data_ram data_ram_i (
    .clk_5M  (clk_5M),
    .ram_req (ram_req),
    .rdata   (ram_rdata)
  );

  display_select display_select_i (
    .clk_5M     (clk_5M),
    .rst        (rst),
    .debug      (debug),
    .debug_word (debug_word),
    .disp_value (disp_value),
    .show_value (show_value)
  );

  seg_scanner seg_scanner_i (
    .clk_5M     (clk_5M),
    .rst        (rst),
    .show_value (show_value),
    .an         (an),
    .sev_out    (sev_out)
  );

  uart_link uart_link_i (
    .clk_5M     (clk_5M),
    .rst        (rst),
    .rx         (rx),
    .tx         (tx),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy),
    .rx_pop     (rx_pop),
    .rx_byte    (rx_byte),
    .rx_present (rx_present)
  );

endmodule

// ==== seg_scanner.sv ====
`timescale 1ns/1ps

module seg_scanner (
  input  logic                       clk_5M,
  input  logic                       rst,
  input  logic [31:0]                show_value,
  output logic [soc_pkg::DIGITS-1:0] an,
  output logic [6:0]                 sev_out
);

  logic [soc_pkg::DIGIT_W-1:0] digit_q;
  logic [soc_pkg::DIGIT_W-1:0] digit_next;
  logic [soc_pkg::DIGITS-1:0]  an_q;
  logic [soc_pkg::DIGITS-1:0]  an_next;
  logic [6:0]                  seg_q;
  logic [3:0]                  nib_next;
  logic [3:0]                  nib_first;

  // digit 7 wraps to digit 0
  always_comb begin
    if (digit_q == soc_pkg::DIGIT_LAST) begin
      digit_next = '0;
    end else begin
      digit_next = digit_q + 1'b1;
    end
  end

  // one anode low, active-low one-hot
  always_comb begin
    an_next = '1;
    an_next[digit_next] = 1'b0;
  end

  // nibble of the digit being switched on
  assign nib_next  = show_value[digit_next*4 +: 4];
  assign nib_first = show_value[3:0];

  // anode and segments load together, so they always match
  always_ff @(posedge clk_5M) begin
    if (rst) begin
      digit_q <= '0;
      an_q    <= {{(soc_pkg::DIGITS-1){1'b1}}, 1'b0};
      seg_q   <= soc_pkg::SEG_TABLE[nib_first];
    end else begin
      digit_q <= digit_next;
      an_q    <= an_next;
      seg_q   <= soc_pkg::SEG_TABLE[nib_next];
    end
  end

  assign an      = an_q;
  assign sev_out = seg_q;

endmodule

// ==== soc_pkg.sv ====
package soc_pkg;

  // data ram depth in 32-bit words
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW = $clog2(RAM_WORDS);

  // region lives in address bits 31..28
  localparam logic [3:0] REGION_RAM = 4'h0;
  localparam logic [3:0] REGION_IO  = 4'h1;

  // io register word indexes
  localparam logic [2:0] IO_DISP      = 3'd0;
  localparam logic [2:0] IO_LED       = 3'd1;
  localparam logic [2:0] IO_UART_TX   = 3'd2;
  localparam logic [2:0] IO_UART_RX   = 3'd3;
  localparam logic [2:0] IO_UART_STAT = 3'd4;

  // clk_5M cycles per uart bit, roughly 115200 baud
  localparam int BAUD_DIV = 43;
  localparam int BAUD_W = $clog2(BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);
  // rx starts half a bit late so samples land mid-bit
  localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(BAUD_DIV / 2);

  // seven-segment digits on the board
  localparam int DIGITS = 8;
  localparam int DIGIT_W = $clog2(DIGITS);
  localparam logic [DIGIT_W-1:0] DIGIT_LAST = DIGIT_W'(DIGITS - 1);

  // active-low segments for hex 0..f, index 0 first
  localparam logic [0:15][6:0] SEG_TABLE = {
    7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,
    7'b1001100, 7'b0100100, 7'b0100000, 7'b0001111,
    7'b0000000, 7'b0000100, 7'b0001000, 7'b1100000,
    7'b0110001, 7'b1000010, 7'b0110000, 7'b0111000
  };

  // address seen as a ram word pointer
  typedef struct packed {
    logic [3:0]         region;
    logic [25-RAM_AW:0] unused;
    logic [RAM_AW-1:0]  word;
    logic [1:0]         byte_off;
  } ram_addr_t;

  // same address seen as an io register pointer
  typedef struct packed {
    logic [3:0]  region;
    logic [22:0] unused;
    logic [2:0]  reg_idx;
    logic [1:0]  byte_off;
  } io_addr_t;

  typedef union packed {
    ram_addr_t ram;
    io_addr_t  io;
  } bus_addr_u;

  // one core-side bus request
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [3:0]  be;
    bus_addr_u   addr;
    logic [31:0] wdata;
  } bus_req_t;

  // request as the ram sees it
  typedef struct packed {
    logic [3:0]        we;
    logic              rd;
    logic [RAM_AW-1:0] word;
    logic [31:0]       wdata;
  } ram_req_t;

  // uart status word, bit 0 rx present, bit 1 tx busy
  typedef struct packed {
    logic [29:0] pad;
    logic        tx_busy;
    logic        rx_present;
  } uart_stat_t;

endpackage

// ==== tb.f ====
soc_pkg.sv
data_ram.sv
display_select.sv
seg_scanner.sv
uart_link.sv
mem_controller.sv
mmio_top.sv
mmio_sva.sv
tb_mmio_top.sv

// ==== tb_mmio_top.sv ====
`timescale 1ns/1ps

module tb_mmio_top;

  logic              clk_5M;
  logic              rst;
  soc_pkg::bus_req_t bus_req;
  logic [31:0]       bus_rdata;
  logic              debug;
  logic [31:0]       debug_word;
  logic              rx;
  logic              tx;
  logic [15:0]       led;
  logic [7:0]        an;
  logic [6:0]        sev_out;

  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  logic [31:0] rd_word;
  logic [31:0] wr_word;
  logic [3:0]  be;
  logic [7:0]  idx;
  logic [7:0]  tx_val;
  logic [31:0] disp_model;
  logic [31:0] led_model;
  logic [31:0] shadow [soc_pkg::RAM_WORDS];
  bit          written [soc_pkg::RAM_WORDS];
  // scan compare process is armed by these
  bit          scan_on;
  logic [31:0] scan_value;
  // digit seen on the previous scanned cycle
  int          scan_prev;
  bit          scan_started;

  mmio_top mmio_top_i (
    .clk_5M     (clk_5M),
    .rst        (rst),
    .bus_req    (bus_req),
    .bus_rdata  (bus_rdata),
    .debug      (debug),
    .debug_word (debug_word),
    .rx         (rx),
    .tx         (tx),
    .led        (led),
    .an         (an),
    .sev_out    (sev_out)
  );

  // uart loopback
  assign rx = tx;

  // 200 ns period
  initial clk_5M = 1'b0;
  always #100 clk_5M = ~clk_5M;

  // expected segment pattern of digit k
  function automatic logic [6:0] seg_of(input logic [31:0] value, input int k);
    return soc_pkg::SEG_TABLE[value[k*4 +: 4]];
  endfunction

  // old word with enabled byte lanes replaced
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  lanes);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] ram_addr(input logic [7:0] word);
    return {soc_pkg::REGION_RAM, 18'h0, word, 2'b00};
  endfunction

  function automatic logic [31:0] io_addr(input logic [2:0] reg_idx);
    return {soc_pkg::REGION_IO, 23'h0, reg_idx, 2'b00};
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one line per finished test
  task automatic report_test(input string name);
    $display("test %s done: %0d checks, %0d errors", name,
             checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  // one-cycle write strobe
  task automatic bus_write(input logic [31:0] addr, input logic [3:0] lanes,
                           input logic [31:0] data);
    soc_pkg::bus_req_t req;
    req       = '0;
    req.wr    = 1'b1;
    req.be    = lanes;
    req.addr  = addr;
    req.wdata = data;
    @(posedge clk_5M);
    bus_req <= req;
    @(posedge clk_5M);
    bus_req <= '0;
  endtask

  // strobe, then sample one cycle later on the falling edge
  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    soc_pkg::bus_req_t req;
    req      = '0;
    req.rd   = 1'b1;
    req.be   = 4'hf;
    req.addr = addr;
    @(posedge clk_5M);
    bus_req <= req;
    @(posedge clk_5M);
    bus_req <= '0;
    @(negedge clk_5M);
    data = bus_rdata;
  endtask

  // poll the status word, rx present or tx idle
  task automatic wait_status(input bit want_rx, input int limit, input string what);
    soc_pkg::uart_stat_t stat;
    logic [31:0]         word;
    bit                  done;
    int                  polls;
    done  = 1'b0;
    polls = 0;
    while (!done && polls < limit) begin
      bus_read(io_addr(soc_pkg::IO_UART_STAT), word);
      stat = word;
      done = want_rx ? stat.rx_present : !stat.tx_busy;
      polls++;
    end
    if (!done) begin
      $display("timeout: %s never seen after %0d status polls", what, polls);
      $display("=== FAIL ===");
      $finish;
    end
  endtask

  // scanner compare, outputs settled on the falling edge
  always @(negedge clk_5M) begin : scan_compare
    int lows;
    int k;
    if (scan_on) begin
      lows = 0;
      k = 0;
      for (int i = 0; i < soc_pkg::DIGITS; i++) begin
        if (!an[i]) begin
          lows++;
          k = i;
        end
      end
      check_equal(lows, 1, "anodes low");
      // one digit further every clock, 7 wraps to 0
      if (scan_started) begin
        check_equal(k, (scan_prev + 1) % soc_pkg::DIGITS, "anode rotation");
      end
      check_equal({25'h0, sev_out}, {25'h0, seg_of(scan_value, k)}, "segments");
      scan_prev    = k;
      scan_started = 1'b1;
    end else begin
      scan_started = 1'b0;
    end
  end

  initial begin
    rst        = 1'b1;
    bus_req    = '0;
    debug      = 1'b0;
    debug_word = 32'h0;
    scan_on    = 1'b0;
    scan_value = 32'h0;
    checks     = 0;
    errors     = 0;
    test_checks = 0;
    test_errors = 0;
    // seeds the generator once
    void'($urandom(32'hb1ed_25f6));
    repeat (16) @(posedge clk_5M);
    rst <= 1'b0;
    @(negedge clk_5M);

    // reset state
    check_equal(led, 32'h0, "led after reset");
    check_equal(bus_rdata, 32'h0, "bus_rdata after reset");
    check_equal(tx, 1'b1, "tx idle after reset");
    check_equal(an, 8'hfe, "anode after reset");
    bus_read(io_addr(soc_pkg::IO_DISP), rd_word);
    check_equal(rd_word, 32'h0, "display after reset");
    bus_read(io_addr(soc_pkg::IO_UART_STAT), rd_word);
    check_equal(rd_word, 32'h0, "status after reset");
    report_test("reset");

    // ram byte lanes against a shadow
    for (int n = 0; n < 24; n++) begin
      idx = $urandom;
      if (!written[idx]) begin
        // a full word first so the shadow is known
        wr_word = $urandom;
        bus_write(ram_addr(idx), 4'hf, wr_word);
        shadow[idx]  = wr_word;
        written[idx] = 1'b1;
      end
      wr_word = $urandom;
      be = $urandom;
      bus_write(ram_addr(idx), be, wr_word);
      shadow[idx] = merge_bytes(shadow[idx], wr_word, be);
      bus_read(ram_addr(idx), rd_word);
      check_equal(rd_word, shadow[idx], "ram word");
    end
    // regions 2..15 are unmapped, low bits alias a written ram word
    wr_word = {4'(2 + $urandom_range(13)), 18'($urandom), idx, 2'b00};
    bus_read(wr_word, rd_word);
    check_equal(rd_word, 32'h0, "unmapped region");
    report_test("ram");

    // display and led registers, partial lanes
    disp_model = $urandom;
    bus_write(io_addr(soc_pkg::IO_DISP), 4'hf, disp_model);
    led_model = 32'h0;
    for (int n = 0; n < 6; n++) begin
      wr_word = $urandom;
      be = $urandom;
      bus_write(io_addr(soc_pkg::IO_DISP), be, wr_word);
      disp_model = merge_bytes(disp_model, wr_word, be);
      bus_read(io_addr(soc_pkg::IO_DISP), rd_word);
      check_equal(rd_word, disp_model, "display readback");
      wr_word = $urandom;
      be = $urandom;
      bus_write(io_addr(soc_pkg::IO_LED), be, wr_word);
      // led register is 16 bits wide
      led_model = merge_bytes(led_model, wr_word, be) & 32'h0000_ffff;
      bus_read(io_addr(soc_pkg::IO_LED), rd_word);
      check_equal(rd_word, led_model, "led readback");
      check_equal(led, led_model, "led port");
    end
    report_test("registers");

    // scan of the display register, then of the debug word
    scan_value = disp_model;
    repeat (3) @(posedge clk_5M);
    scan_on = 1'b1;
    repeat (16) @(posedge clk_5M);
    scan_on = 1'b0;
    debug_word <= $urandom;
    debug <= 1'b1;
    @(posedge clk_5M);
    scan_value = debug_word;
    repeat (3) @(posedge clk_5M);
    scan_on = 1'b1;
    repeat (16) @(posedge clk_5M);
    scan_on = 1'b0;
    debug <= 1'b0;
    report_test("scan");

    // uart bytes through the loopback
    for (int n = 0; n < 4; n++) begin
      wait_status(1'b0, 400, "tx idle");
      tx_val = $urandom;
      bus_write(io_addr(soc_pkg::IO_UART_TX), 4'b0001, {24'h0, tx_val});
      wait_status(1'b1, 400, "rx present");
      bus_read(io_addr(soc_pkg::IO_UART_RX), rd_word);
      check_equal(rd_word, {24'h0, tx_val}, "received byte");
      bus_read(io_addr(soc_pkg::IO_UART_STAT), rd_word);
      check_equal(rd_word[0], 1'b0, "rx present after read");
    end
    report_test("uart");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== uart_link.sv ====
`timescale 1ns/1ps

module uart_link (
  input  logic       clk_5M,
  input  logic       rst,
  input  logic       rx,
  output logic       tx,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  input  logic       rx_pop,
  output logic [7:0] rx_byte,
  output logic       rx_present
);

  // transmit side
  logic                        tx_q;
  logic                        tx_busy_q;
  logic [8:0]                  tx_shift;
  logic [soc_pkg::BAUD_W-1:0]  tx_cnt;
  logic [3:0]                  tx_bit;

  // receive side
  logic                        rx_s1;
  logic                        rx_s2;
  logic                        rx_active;
  logic [soc_pkg::BAUD_W-1:0]  rx_cnt;
  logic [3:0]                  rx_bit;
  logic [7:0]                  rx_shift;
  logic [7:0]                  rx_hold;
  logic                        rx_present_q;

  // start bit goes out at the start edge, data and stop follow
  always_ff @(posedge clk_5M) begin
    if (rst) begin
      tx_q      <= 1'b1;
      tx_busy_q <= 1'b0;
      tx_cnt    <= '0;
      tx_bit    <= 4'd0;
    end else if (!tx_busy_q) begin
      if (tx_start) begin
        tx_q      <= 1'b0;
        tx_busy_q <= 1'b1;
        tx_cnt    <= '0;
        tx_bit    <= 4'd0;
      end
    end else if (tx_cnt == soc_pkg::BAUD_LAST) begin
      tx_cnt <= '0;
      if (tx_bit == 4'd9) begin
        // stop bit done, line already idle high
        tx_busy_q <= 1'b0;
      end else begin
        tx_q   <= tx_shift[0];
        tx_bit <= tx_bit + 4'd1;
      end
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  // lsb first, stop bit rides at the top
  always_ff @(posedge clk_5M) begin
    if (!tx_busy_q && tx_start) begin
      tx_shift <= {1'b1, tx_byte};
    end else if (tx_busy_q && tx_cnt == soc_pkg::BAUD_LAST) begin
      tx_shift <= {1'b1, tx_shift[8:1]};
    end
  end

  // two-flop synchronizer, idles high
  always_ff @(posedge clk_5M) begin
    if (rst) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
    end
  end

  // bit 0 start check, 1..8 data, 9 stop
  always_ff @(posedge clk_5M) begin
    if (rst) begin
      rx_active    <= 1'b0;
      rx_cnt       <= '0;
      rx_bit       <= 4'd0;
      rx_present_q <= 1'b0;
    end else begin
      if (rx_pop) begin
        rx_present_q <= 1'b0;
      end
      if (!rx_active) begin
        if (!rx_s2) begin
          rx_active <= 1'b1;
          rx_cnt    <= soc_pkg::BAUD_HALF;
          rx_bit    <= 4'd0;
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        rx_cnt <= soc_pkg::BAUD_LAST;
        rx_bit <= rx_bit + 4'd1;
        if (rx_bit == 4'd0 && rx_s2) begin
          // glitch, not a real start bit
          rx_active <= 1'b0;
        end else if (rx_bit == 4'd9) begin
          rx_active <= 1'b0;
          // new byte beats a pop in the same cycle
          if (rx_s2) begin
            rx_present_q <= 1'b1;
          end
        end
      end
    end
  end

  // data path of the receiver
  always_ff @(posedge clk_5M) begin
    if (rx_active && rx_cnt == '0) begin
      if (rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
        rx_shift <= {rx_s2, rx_shift[7:1]};
      end
      // unread byte simply gets overwritten
      if (rx_bit == 4'd9 && rx_s2) begin
        rx_hold <= rx_shift;
      end
    end
  end

  assign tx         = tx_q;
  assign tx_busy    = tx_busy_q;
  assign rx_byte    = rx_hold;
  assign rx_present = rx_present_q;

endmodule
